// ==== src/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // widths
    localparam int X_W     = 10;
    localparam int Y_W     = 9;
    localparam int COLOR_W = 4;
    localparam int LUMA_W  = 6;
    localparam int PHASE_W = 8;
    localparam int AMP_W   = 4;

    localparam int PAL_ENTRIES = 16;            // one entry per pixel colour
    localparam int DOT_DIV     = 4;             // col16x clocks per dot

    // raster geometry, x in dots and y in lines
    localparam logic [X_W-1:0] NTSC_X_LAST       = 10'd519;
    localparam logic [X_W-1:0] PAL_X_LAST        = 10'd503;
    localparam logic [Y_W-1:0] NTSC_Y_LAST       = 9'd262;
    localparam logic [Y_W-1:0] PAL_Y_LAST        = 9'd311;
    localparam logic [X_W-1:0] NTSC_HSYNC_START  = 10'd8;   // ~1us after line start
    localparam logic [X_W-1:0] NTSC_HSYNC_END    = 10'd45;  // exclusive
    localparam logic [X_W-1:0] PAL_HSYNC_START   = 10'd7;
    localparam logic [X_W-1:0] PAL_HSYNC_END     = 10'd44;
    localparam logic [X_W-1:0] NTSC_HVIS_START   = 10'd96;
    localparam logic [X_W-1:0] PAL_HVIS_START    = 10'd91;
    localparam logic [Y_W-1:0] NTSC_VBLANK_START = 9'd14;
    localparam logic [Y_W-1:0] PAL_VBLANK_START  = 9'd301;

    // vertical blanking: 3 eq lines, 3 serration lines, 3 eq lines
    localparam logic [Y_W-1:0] VBLANK_LINES = 9'd9;
    localparam logic [Y_W-1:0] EQ_LINES     = 9'd3;
    localparam logic [X_W-1:0] EQ_WIDTH     = 10'd18;  // eq pulse low time
    localparam logic [X_W-1:0] SE_WIDTH     = 10'd37;  // serration high gap

    localparam logic [LUMA_W-1:0] NTSC_BLANK_LEVEL = 6'd24;
    localparam logic [LUMA_W-1:0] PAL_BLANK_LEVEL  = 6'd8;

    // colour burst, 9 subcarrier periods of 16 samples
    localparam logic [X_W-1:0]     BURST_START_NTSC     = 10'd50;
    localparam logic [X_W-1:0]     BURST_START_PAL      = 10'd49;
    localparam logic [7:0]         BURST_CYCLES         = 8'd144;
    localparam logic [AMP_W-1:0]   BURST_AMPLITUDE      = 4'd12;
    localparam logic [PHASE_W-1:0] BURST_PHASE_NTSC     = 8'd128;  // 180 deg
    localparam logic [PHASE_W-1:0] BURST_PHASE_PAL_EVEN = 8'd96;   // 135 deg
    localparam logic [PHASE_W-1:0] BURST_PHASE_PAL_ODD  = 8'd160;  // -135 deg

    localparam logic [LUMA_W-1:0] CHROMA_ZERO = 6'd32;   // top 6 bits of SINE_OFFSET

    // sine samples at 0, 22.5, 45 and 67.5 degrees, index 0 in the low byte
    localparam logic [3:0][7:0] QUARTER_SINE = {8'd117, 8'd90, 8'd49, 8'd0};
    localparam logic [7:0]      SINE_PEAK    = 8'd127;   // 90 deg
    localparam logic [8:0]      SINE_OFFSET  = 9'd256;   // dc level of the 9 bit wave

endpackage

`default_nettype wire

// ==== src/palette_regs.sv ====
`default_nettype none

module palette_regs import video_pkg::*; (
    input  wire                clk_col16x,
    input  wire                rst,
    input  wire                pal_req,        // four-phase request
    input  wire  [COLOR_W-1:0] pal_addr,
    input  wire  [LUMA_W-1:0]  pal_luma,
    input  wire  [PHASE_W-1:0] pal_phase,
    input  wire  [AMP_W-1:0]   pal_amp,
    output logic               pal_ack,
    input  wire                dot_stb,
    input  wire  [COLOR_W-1:0] pixel_color,
    output logic [LUMA_W-1:0]  cur_luma,
    output logic [PHASE_W-1:0] cur_phase,
    output logic [AMP_W-1:0]   cur_amp
);

    logic [LUMA_W-1:0]  luma_tab  [PAL_ENTRIES];
    logic [PHASE_W-1:0] phase_tab [PAL_ENTRIES];
    logic [AMP_W-1:0]   amp_tab   [PAL_ENTRIES];

    // write side
    // entry is written once per request, on the req-high/ack-low edge
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            pal_ack <= 1'b0;
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                luma_tab[i]  <= '0;
                phase_tab[i] <= '0;
                amp_tab[i]   <= '0;
            end
        end else begin
            if (pal_req && !pal_ack) begin
                luma_tab[pal_addr]  <= pal_luma;
                phase_tab[pal_addr] <= pal_phase;
                amp_tab[pal_addr]   <= pal_amp;
                pal_ack             <= 1'b1;     // ack one clock after req
            end else if (!pal_req) begin
                pal_ack <= 1'b0;                 // release follows req drop
            end
        end
    end

    // pixel lookup, sampled at the dot strobe
    always_ff @(posedge clk_col16x) begin
        if (dot_stb) begin
            cur_luma  <= luma_tab[pixel_color];
            cur_phase <= phase_tab[pixel_color];
            cur_amp   <= amp_tab[pixel_color];
        end
    end

    // ack only ever answers a live request
    ack_follows_req: assert property (
        @(posedge clk_col16x) disable iff (rst)
        $rose(pal_ack) |-> $past(pal_req)
    );

endmodule

`default_nettype wire

// ==== src/raster_timer.sv ====
`default_nettype none

module raster_timer import video_pkg::*; (
    input  wire            clk_col16x,
    input  wire            rst,
    input  wire            standard,      // 0 ntsc, 1 pal
    output logic           dot_stb,
    output logic [X_W-1:0] raster_x,
    output logic [Y_W-1:0] raster_y,
    output logic           hsync,
    output logic           vsync_eq,      // equalization pulse
    output logic           vsync_se,      // serration pulse
    output logic           vblank_line,
    output logic           visible
);

    logic [$clog2(DOT_DIV)-1:0] div_cnt;
    logic [X_W-1:0] x_last, hs_start, hs_end, hvis_start, x_half;
    logic [Y_W-1:0] y_last, vb_start, vb_idx;
    logic [X_W-1:0] x_nxt;
    logic [Y_W-1:0] y_nxt;
    logic           vb_n, se_line_n, eq_pulse_n, se_gap_n;

    // per-standard geometry
    assign x_last     = standard ? PAL_X_LAST : NTSC_X_LAST;
    assign y_last     = standard ? PAL_Y_LAST : NTSC_Y_LAST;
    assign hs_start   = standard ? PAL_HSYNC_START : NTSC_HSYNC_START;
    assign hs_end     = standard ? PAL_HSYNC_END : NTSC_HSYNC_END;
    assign hvis_start = standard ? PAL_HVIS_START : NTSC_HVIS_START;
    assign vb_start   = standard ? PAL_VBLANK_START : NTSC_VBLANK_START;
    assign x_half     = (x_last + 1'b1) >> 1;   // 260 ntsc, 252 pal

    // position after the coming strobe
    always_comb begin
        x_nxt = raster_x + 1'b1;
        y_nxt = raster_y;
        if (raster_x == x_last) begin
            x_nxt = '0;
            y_nxt = (raster_y == y_last) ? '0 : raster_y + 1'b1;
        end
    end

    // region decode of the next position, flags line up with x/y
    assign vb_n      = (y_nxt >= vb_start) && (y_nxt < vb_start + VBLANK_LINES);
    assign vb_idx    = y_nxt - vb_start;                 // line within vblank
    assign se_line_n = vb_n && (vb_idx >= EQ_LINES) && (vb_idx < VBLANK_LINES - EQ_LINES);
    assign eq_pulse_n = (x_nxt < EQ_WIDTH) ||
                        ((x_nxt >= x_half) && (x_nxt < x_half + EQ_WIDTH));
    // serration goes back high for the last SE_WIDTH dots of each half line
    assign se_gap_n  = ((x_nxt >= x_half - SE_WIDTH) && (x_nxt < x_half)) ||
                       (x_nxt > x_last - SE_WIDTH);

    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            div_cnt     <= '0;
            dot_stb     <= 1'b0;
            raster_x    <= '0;
            raster_y    <= '0;
            hsync       <= 1'b0;     // (0,0) decodes to all flags low
            vsync_eq    <= 1'b0;
            vsync_se    <= 1'b0;
            vblank_line <= 1'b0;
            visible     <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;                   // DOT_DIV is a power of 2
            dot_stb <= (div_cnt == $bits(div_cnt)'(DOT_DIV - 1));
            if (dot_stb) begin
                raster_x    <= x_nxt;
                raster_y    <= y_nxt;
                hsync       <= (x_nxt >= hs_start) && (x_nxt < hs_end);
                vblank_line <= vb_n;
                vsync_eq    <= vb_n && !se_line_n && eq_pulse_n;
                vsync_se    <= se_line_n && !se_gap_n;
                visible     <= !vb_n && (x_nxt >= hvis_start);
            end
        end
    end

    sync_not_visible: assert property (
        @(posedge clk_col16x) disable iff (rst)
        (hsync || vblank_line) |-> !visible
    );

endmodule

`default_nettype wire

// ==== src/sine_rom.sv ====
`default_nettype none

module sine_rom import video_pkg::*; (
    input  wire        clk_col16x,
    input  wire  [3:0] addr_amp,     // amplitude code, 0 gives the flat level
    input  wire  [3:0] addr_phase,   // top nibble of the phase sum
    output logic [8:0] dout
);

    logic [1:0]  quadrant;
    logic [1:0]  step;
    logic [7:0]  mag;
    logic [11:0] prod;
    logic [7:0]  scaled;

    assign quadrant = addr_phase[3:2];
    assign step     = addr_phase[1:0];

    // quarter-wave table, mirrored on odd quadrants
    always_comb begin
        if (!quadrant[0]) begin
            mag = QUARTER_SINE[step];
        end else if (step == 2'd0) begin
            mag = SINE_PEAK;                     // 90 and 270 deg
        end else begin
            mag = QUARTER_SINE[2'd0 - step];     // 4 - step
        end
    end

    assign prod   = {4'd0, mag} * {8'd0, addr_amp};
    assign scaled = prod[11:4];                  // amplitude is in 16ths

    // lower half of the wave in quadrants 2 and 3
    always_ff @(posedge clk_col16x) begin
        if (quadrant[1]) begin
            dout <= SINE_OFFSET - {1'b0, scaled};
        end else begin
            dout <= SINE_OFFSET + {1'b0, scaled};
        end
    end

endmodule

`default_nettype wire

// ==== src/chroma_modulator.sv ====
`default_nettype none

module chroma_modulator import video_pkg::*; (
    input  wire                clk_col16x,
    input  wire                rst,
    input  wire                standard,
    input  wire  [X_W-1:0]     raster_x,
    input  wire  [Y_W-1:0]     raster_y,
    input  wire                visible,
    input  wire                vblank_line,
    input  wire  [PHASE_W-1:0] cur_phase,
    input  wire  [AMP_W-1:0]   cur_amp,
    output logic [LUMA_W-1:0]  chroma
);

    logic [3:0]         phase_cnt;       // 16 samples per subcarrier period
    logic [Y_W-1:0]     prev_y;
    logic               need_burst, in_burst, burst_go, burst_on;
    logic [7:0]         burst_cnt;
    logic [X_W-1:0]     burst_start;
    logic               odd_pal;
    logic [AMP_W-1:0]   amp_sel;
    logic [PHASE_W-1:0] phase_sel, burst_phase, phase_sum;
    logic [AMP_W-1:0]   rom_amp, amp_d2;   // amplitude follows the rom pipe
    logic [3:0]         rom_phase;
    logic [8:0]         sine_val;

    assign burst_start = standard ? BURST_START_PAL : BURST_START_NTSC;
    assign odd_pal     = standard && raster_y[0];
    assign burst_go    = need_burst && (raster_x >= burst_start);
    assign burst_on    = burst_go || in_burst;   // high from the very first clock

    // pal swings the burst between 135 and -135 deg line by line
    assign burst_phase = !standard ? BURST_PHASE_NTSC :
                         (raster_y[0] ? BURST_PHASE_PAL_ODD : BURST_PHASE_PAL_EVEN);

    always_comb begin
        if (vblank_line) begin
            amp_sel = '0;                        // no colour in vertical sync
        end else if (visible) begin
            amp_sel = cur_amp;
        end else if (burst_on) begin
            amp_sel = BURST_AMPLITUDE;
        end else begin
            amp_sel = '0;
        end
    end

    assign phase_sel = visible ? (odd_pal ? ~cur_phase : cur_phase) : burst_phase;  // ~p is 255-p
    assign phase_sum = {phase_cnt, 4'b0000} + phase_sel;

    // phase counter and burst control
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            phase_cnt  <= '0;
            prev_y     <= '0;
            need_burst <= 1'b1;                  // line 0 gets its burst too
            in_burst   <= 1'b0;
            burst_cnt  <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
            prev_y    <= raster_y;
            if (burst_go) begin
                need_burst <= 1'b0;
                in_burst   <= 1'b1;
                burst_cnt  <= 8'd1;              // go clock is sample 0
            end else if (in_burst) begin
                burst_cnt <= burst_cnt + 1'b1;
                if (burst_cnt == BURST_CYCLES - 1'b1) in_burst <= 1'b0;
            end
            if (raster_y != prev_y) need_burst <= 1'b1;   // new line, arm burst
        end
    end

    // rom address stage, rom read, then output select
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            rom_amp <= '0;
            amp_d2  <= '0;
            chroma  <= CHROMA_ZERO;
        end else begin
            rom_amp <= amp_sel;
            amp_d2  <= rom_amp;                  // aligned with sine_val
            chroma  <= (amp_d2 == '0) ? CHROMA_ZERO : sine_val[8:3];
        end
    end

    always_ff @(posedge clk_col16x) begin
        rom_phase <= phase_sum[7:4];
    end

    sine_rom sine_rom_inst (
        .clk_col16x (clk_col16x),
        .addr_amp   (rom_amp),
        .addr_phase (rom_phase),
        .dout       (sine_val)
    );

    burst_length: assert property (
        @(posedge clk_col16x) disable iff (rst)
        $rose(burst_on) |-> ##BURST_CYCLES !burst_on
    );

endmodule

`default_nettype wire

// ==== src/luma_mixer.sv ====
`default_nettype none

module luma_mixer import video_pkg::*; (
    input  wire               clk_col16x,
    input  wire               rst,
    input  wire               standard,
    input  wire               dot_stb,
    input  wire               hsync,
    input  wire               vsync_eq,
    input  wire               vsync_se,
    input  wire               vblank_line,
    input  wire               visible,
    input  wire  [LUMA_W-1:0] cur_luma,
    output logic [LUMA_W-1:0] luma,
    output logic              luma_sink    // pull output to sync tip
);

    logic              stb_d;              // flags and palette settle a clock after strobe
    logic              vs_pulse;
    logic [LUMA_W-1:0] blank_level;

    assign blank_level = standard ? PAL_BLANK_LEVEL : NTSC_BLANK_LEVEL;
    assign vs_pulse    = vsync_eq || vsync_se;

    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            stb_d     <= 1'b0;
            luma      <= '0;
            luma_sink <= 1'b0;
        end else begin
            stb_d <= dot_stb;
            if (stb_d) begin
                if (vblank_line) begin
                    // vertical sync lines carry only eq or serration pulses
                    luma      <= vs_pulse ? '0 : blank_level;
                    luma_sink <= vs_pulse;
                end else if (hsync) begin
                    luma      <= '0;
                    luma_sink <= 1'b1;
                end else if (!visible) begin
                    luma      <= blank_level;    // front and back porch
                    luma_sink <= 1'b0;
                end else begin
                    luma      <= cur_luma;
                    luma_sink <= 1'b0;
                end
            end
        end
    end

    sink_at_sync_tip: assert property (
        @(posedge clk_col16x) disable iff (rst)
        luma_sink |-> (luma == '0)
    );

endmodule

`default_nettype wire

// ==== src/comp_video.sv ====
`default_nettype none

module comp_video import video_pkg::*; (
    input  wire                clk_col16x,
    input  wire                rst,
    input  wire                standard,       // 0 ntsc, 1 pal, static
    input  wire  [COLOR_W-1:0] pixel_color,
    input  wire                pal_req,
    input  wire  [COLOR_W-1:0] pal_addr,
    input  wire  [LUMA_W-1:0]  pal_luma,
    input  wire  [PHASE_W-1:0] pal_phase,
    input  wire  [AMP_W-1:0]   pal_amp,
    output wire                pal_ack,
    output wire  [X_W-1:0]     raster_x,
    output wire  [Y_W-1:0]     raster_y,
    output wire  [LUMA_W-1:0]  luma,
    output wire                luma_sink,
    output wire  [LUMA_W-1:0]  chroma
);

    wire               dot_stb;
    wire               hsync, vsync_eq, vsync_se, vblank_line, visible;
    wire [LUMA_W-1:0]  cur_luma;
    wire [PHASE_W-1:0] cur_phase;
    wire [AMP_W-1:0]   cur_amp;

    palette_regs palette_regs_inst (
        .clk_col16x (clk_col16x), .rst (rst),
        .pal_req (pal_req), .pal_addr (pal_addr), .pal_luma (pal_luma),
        .pal_phase (pal_phase), .pal_amp (pal_amp), .pal_ack (pal_ack),
        .dot_stb (dot_stb), .pixel_color (pixel_color),
        .cur_luma (cur_luma), .cur_phase (cur_phase), .cur_amp (cur_amp)
    );

    raster_timer raster_timer_inst (
        .clk_col16x (clk_col16x), .rst (rst), .standard (standard),
        .dot_stb (dot_stb), .raster_x (raster_x), .raster_y (raster_y),
        .hsync (hsync), .vsync_eq (vsync_eq), .vsync_se (vsync_se),
        .vblank_line (vblank_line), .visible (visible)
    );

    chroma_modulator chroma_modulator_inst (
        .clk_col16x (clk_col16x), .rst (rst), .standard (standard),
        .raster_x (raster_x), .raster_y (raster_y), .visible (visible),
        .vblank_line (vblank_line), .cur_phase (cur_phase), .cur_amp (cur_amp),
        .chroma (chroma)
    );

    luma_mixer luma_mixer_inst (
        .clk_col16x (clk_col16x), .rst (rst), .standard (standard),
        .dot_stb (dot_stb), .hsync (hsync), .vsync_eq (vsync_eq),
        .vsync_se (vsync_se), .vblank_line (vblank_line), .visible (visible),
        .cur_luma (cur_luma), .luma (luma), .luma_sink (luma_sink)
    );

endmodule

`default_nettype wire

// ==== test/comp_video_checker.sv ====
`default_nettype none

module comp_video_checker import video_pkg::*; (
    input  wire                clk_col16x,
    input  wire                rst,
    input  wire                standard,
    input  wire  [COLOR_W-1:0] pixel_color,
    input  wire  [X_W-1:0]     raster_x,
    input  wire  [Y_W-1:0]     raster_y,
    input  wire  [LUMA_W-1:0]  luma,
    input  wire                luma_sink,
    input  wire  [LUMA_W-1:0]  chroma,
    input  wire                check_en,
    input  wire  [LUMA_W-1:0]  shadow_luma  [PAL_ENTRIES],
    input  wire  [PHASE_W-1:0] shadow_phase [PAL_ENTRIES],
    input  wire  [AMP_W-1:0]   shadow_amp   [PAL_ENTRIES],
    output int                 error_count,
    output int                 luma_checks,
    output int                 chroma_checks
);

    logic rst_p;                     // inputs as seen at the last rising edge
    logic [COLOR_W-1:0] pix_p;
    int   x_s, y_s;                  // raster position seen at the previous falling edge
    int   cur_pix, pc, rem, ylm;
    int   mx, my, stb_gap;           // model raster position and clocks since its last step
    logic armed, luma_pending;
    logic [LUMA_W-1:0] exp_hist [3]; // expected chroma of the last three edges

    initial begin
        error_count   = 0;
        luma_checks   = 0;
        chroma_checks = 0;
        x_s     = 0;
        y_s     = 0;
        cur_pix = 0;
        pc      = 0;
        rem     = 0;
        ylm     = 0;
        mx      = 0;
        my      = 0;
        stb_gap = 0;
        armed = 1'b1;
        luma_pending = 1'b0;
        for (int i = 0; i < 3; i++) exp_hist[i] = CHROMA_ZERO;
    end

    // {sink, luma} of a raster position by region
    function automatic logic [6:0] ref_luma(input int x, input int y, input logic std,
                                            input logic [5:0] pix_luma);
        int xl, vbs, idx, half, hs0, hs1, hv;
        logic vb, eq, gap, pulse;
        logic [5:0] blank;
        xl    = std ? 503 : 519;
        vbs   = std ? 301 : 14;
        hs0   = std ? 7 : 8;
        hs1   = std ? 44 : 45;
        hv    = std ? 91 : 96;
        blank = std ? 6'd8 : 6'd24;
        half  = (xl + 1) / 2;
        idx   = y - vbs;
        vb    = (idx >= 0) && (idx < 9);
        eq    = (x < 18) || ((x >= half) && (x < half + 18));
        gap   = ((x >= half - 37) && (x < half)) || (x > xl - 37);   // serration high gaps
        pulse = (idx >= 3 && idx < 6) ? !gap : eq;
        if (vb) return pulse ? 7'b1_000000 : {1'b0, blank};
        if (x >= hs0 && x < hs1) return 7'b1_000000;
        if (x < hv) return {1'b0, blank};
        return {1'b0, pix_luma};
    endfunction

    // sine rule with quadrant from idx[3:2] and 127 at the odd-quadrant edge
    function automatic logic [5:0] ref_chroma(input int idx, input int amp);
        int q, s, mag, scaled, val;
        q = idx / 4;
        s = idx % 4;
        if (q % 2 == 0) mag = QUARTER_SINE[s];
        else if (s == 0) mag = 127;
        else mag = QUARTER_SINE[4 - s];
        scaled = (mag * amp) / 16;
        val = (q >= 2) ? 256 - scaled : 256 + scaled;
        return 6'(val >> 3);
    endfunction

    always @(posedge clk_col16x) begin
        rst_p <= rst;
        pix_p <= pixel_color;
    end

    always @(negedge clk_col16x) begin
        logic vb, vis, on, odd;
        int   amp, ph, idx, vbs, xl, yl;
        logic [6:0] le;
        if (rst_p) begin
            pc      = 0;
            rem     = 0;
            ylm     = 0;
            mx      = 0;
            my      = 0;
            stb_gap = -1;                        // x first moves a clock after the first strobe
            armed = 1'b1;
            luma_pending = 1'b0;
            exp_hist[2] = exp_hist[1];
            exp_hist[1] = exp_hist[0];
            exp_hist[0] = CHROMA_ZERO;
        end else begin
            // expected chroma for the edge just passed uses the state before it
            vbs = standard ? 301 : 14;
            vb  = (y_s >= vbs) && (y_s < vbs + 9);
            vis = !vb && (x_s >= (standard ? 91 : 96));
            odd = standard && (y_s % 2 == 1);
            on  = (armed && x_s >= (standard ? 49 : 50)) || (rem != 0);
            amp = vb ? 0 : vis ? int'(shadow_amp[cur_pix]) : on ? 12 : 0;
            if (vis) ph = odd ? 255 - int'(shadow_phase[cur_pix]) : int'(shadow_phase[cur_pix]);
            else ph = !standard ? 128 : odd ? 160 : 96;
            idx = ((pc * 16 + ph) % 256) / 16;
            exp_hist[2] = exp_hist[1];
            exp_hist[1] = exp_hist[0];
            exp_hist[0] = ref_chroma(idx, amp);
            if (on && rem == 0) begin
                armed = 1'b0;
                rem = BURST_CYCLES - 1;          // first burst clock already counted
            end else if (rem > 0) begin
                rem = rem - 1;
            end
            if (y_s != ylm) armed = 1'b1;        // new line arms the next burst
            ylm = y_s;
            pc = (pc + 1) % 16;

            if (check_en) begin
                chroma_checks++;
                if (chroma !== exp_hist[2]) begin
                    error_count++;
                    if (error_count <= 20)
                        $display("Mismatch at %0t: chroma exp %0d got %0d at x %0d y %0d",
                                 $time, exp_hist[2], chroma, x_s, y_s);
                end
            end

            // raster model steps once every DOT_DIV clocks
            xl = standard ? 503 : 519;
            yl = standard ? 311 : 262;
            stb_gap++;
            if (stb_gap == DOT_DIV) begin
                stb_gap = 0;
                if (mx == xl) begin
                    mx = 0;
                    my = (my == yl) ? 0 : my + 1;
                end else begin
                    mx = mx + 1;
                end
            end
            if (check_en && (int'(raster_x) != mx || int'(raster_y) != my)) begin
                error_count++;
                if (error_count <= 20)
                    $display("Mismatch at %0t: raster exp x %0d y %0d got x %0d y %0d",
                             $time, mx, my, raster_x, raster_y);
            end

            // luma settles one clock after the position moved
            if (luma_pending && check_en) begin
                le = ref_luma(int'(raster_x), int'(raster_y), standard, shadow_luma[cur_pix]);
                luma_checks++;
                if ({luma_sink, luma} !== le) begin
                    error_count++;
                    if (error_count <= 20)
                        $display("Mismatch at %0t: luma exp %0d/%0b got %0d/%0b at x %0d y %0d",
                                 $time, le[5:0], le[6], luma, luma_sink, raster_x, raster_y);
                end
            end
            luma_pending = 1'b0;
            if (int'(raster_x) != x_s) begin     // a dot strobe just moved x
                cur_pix = int'(pix_p);
                luma_pending = 1'b1;
            end
        end
        x_s = int'(raster_x);
        y_s = int'(raster_y);
    end

endmodule

`default_nettype wire

// ==== test/comp_video_tb.sv ====
`default_nettype none

module comp_video_tb import video_pkg::*; ();

    localparam int WAIT_LIMIT  = 64;       // clocks for one handshake phase
    localparam int FRAME_LIMIT = 700000;   // clocks for a frame-long wait

    logic               clk_col16x = 1'b0;
    logic               rst, standard, pal_req, check_en;
    logic [COLOR_W-1:0] pixel_color, pal_addr;
    logic [LUMA_W-1:0]  pal_luma;
    logic [PHASE_W-1:0] pal_phase;
    logic [AMP_W-1:0]   pal_amp;
    wire                pal_ack, luma_sink;
    wire  [X_W-1:0]     raster_x;
    wire  [Y_W-1:0]     raster_y;
    wire  [LUMA_W-1:0]  luma, chroma;
    int                 error_count, luma_checks, chroma_checks;
    int                 tb_errors = 0;
    logic               timed_out = 1'b0;
    logic [31:0]        pal_rng = 32'h53064bff;
    logic [31:0]        pix_rng = 32'h53064bff;
    logic [LUMA_W-1:0]  shadow_luma  [PAL_ENTRIES];
    logic [PHASE_W-1:0] shadow_phase [PAL_ENTRIES];
    logic [AMP_W-1:0]   shadow_amp   [PAL_ENTRIES];

    always #20 clk_col16x = ~clk_col16x;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    comp_video comp_video_inst (
        .clk_col16x (clk_col16x), .rst (rst), .standard (standard),
        .pixel_color (pixel_color), .pal_req (pal_req), .pal_addr (pal_addr),
        .pal_luma (pal_luma), .pal_phase (pal_phase), .pal_amp (pal_amp),
        .pal_ack (pal_ack), .raster_x (raster_x), .raster_y (raster_y),
        .luma (luma), .luma_sink (luma_sink), .chroma (chroma)
    );

    comp_video_checker checker_inst (
        .clk_col16x (clk_col16x), .rst (rst), .standard (standard),
        .pixel_color (pixel_color), .raster_x (raster_x), .raster_y (raster_y),
        .luma (luma), .luma_sink (luma_sink), .chroma (chroma), .check_en (check_en),
        .shadow_luma (shadow_luma), .shadow_phase (shadow_phase), .shadow_amp (shadow_amp),
        .error_count (error_count), .luma_checks (luma_checks), .chroma_checks (chroma_checks)
    );

    // new random pixel every falling edge and the DUT picks one per dot
    always @(negedge clk_col16x) begin
        pix_rng     = lcg_next(pix_rng);
        pixel_color <= pix_rng[27:24];
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(negedge clk_col16x);
        rst = 1'b0;
        @(negedge clk_col16x);
        if (pal_ack !== 1'b0 || luma_sink !== 1'b0 || chroma !== CHROMA_ZERO ||
            raster_x !== '0 || raster_y !== '0) begin
            tb_errors++;
            $display("Mismatch at %0t: after reset ack %0b sink %0b chroma %0d x %0d y %0d",
                     $time, pal_ack, luma_sink, chroma, raster_x, raster_y);
        end
    endtask

    task automatic write_entry(input int addr);
        int n;
        pal_rng   = lcg_next(pal_rng);
        pal_addr  = COLOR_W'(addr);
        pal_luma  = pal_rng[29:24];
        pal_phase = pal_rng[23:16];
        pal_amp   = (addr == 5) ? 4'd0 : pal_rng[15:12];   // one colour without chroma
        @(negedge clk_col16x);                             // data sits a clock ahead of req
        if (pal_ack !== 1'b0) begin
            tb_errors++;
            $display("pal_ack went high with no request at time %0t", $time);
        end
        pal_req = 1'b1;
        for (n = 0; n < WAIT_LIMIT && pal_ack !== 1'b1; n++) @(negedge clk_col16x);
        if (pal_ack !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: pal_ack never rose for entry %0d", addr);
            return;
        end
        @(negedge clk_col16x);                             // req held one clock longer
        if (pal_ack !== 1'b1) begin
            tb_errors++;
            $display("pal_ack dropped while pal_req was still high at time %0t", $time);
        end
        shadow_luma[addr]  = pal_luma;
        shadow_phase[addr] = pal_phase;
        shadow_amp[addr]   = pal_amp;
        pal_req = 1'b0;
        for (n = 0; n < WAIT_LIMIT && pal_ack !== 1'b0; n++) @(negedge clk_col16x);
        if (pal_ack !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: pal_ack stayed high after pal_req dropped");
        end
    endtask

    task automatic wait_for_line(input int line);
        int n;
        for (n = 0; n < FRAME_LIMIT && int'(raster_y) != line; n++) @(negedge clk_col16x);
        if (int'(raster_y) != line) begin
            timed_out = 1'b1;
            $display("timeout: raster never reached line %0d", line);
        end
    endtask

    task automatic run_standard(input logic std);
        int errs_before;
        standard = std;
        errs_before = tb_errors;
        apply_reset();
        for (int a = 0; a < PAL_ENTRIES && !timed_out; a++) write_entry(a);
        $display("test palette handshake %s: %0d errors", std ? "pal" : "ntsc",
                 tb_errors - errs_before);
        if (timed_out) return;
        repeat (16) @(negedge clk_col16x);      // lookup and chroma pipe see the new table
        errs_before = error_count;
        check_en = 1'b1;
        wait_for_line(std ? PAL_Y_LAST : NTSC_Y_LAST);
        if (!timed_out) wait_for_line(0);
        check_en = 1'b0;
        $display("test full frame %s: %0d mismatches", std ? "pal" : "ntsc",
                 error_count - errs_before);
    endtask

    initial begin
        rst         = 1'b1;
        standard    = 1'b0;
        pixel_color = '0;
        pal_req     = 1'b0;
        pal_addr    = '0;
        pal_luma    = '0;
        pal_phase   = '0;
        pal_amp     = '0;
        check_en    = 1'b0;
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            shadow_luma[i]  = '0;
            shadow_phase[i] = '0;
            shadow_amp[i]   = '0;
        end
        @(negedge clk_col16x);
        run_standard(1'b0);
        if (!timed_out) run_standard(1'b1);
        $display("luma checks %0d, chroma checks %0d, errors %0d, timeout %0b",
                 luma_checks, chroma_checks, tb_errors + error_count, timed_out);
        if (!timed_out && tb_errors == 0 && error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== comp_video.f ====
src/video_pkg.sv
src/palette_regs.sv
src/raster_timer.sv
src/sine_rom.sv
src/chroma_modulator.sv
src/luma_mixer.sv
src/comp_video.sv
test/comp_video_checker.sv
test/comp_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f comp_video.f \
    --top-module comp_video_tb -o comp_video_sim > build.log 2>&1 \
    && ./obj_dir/comp_video_sim > sim.log 2>&1 \
    || echo "build or simulation step failed"
grep -q "Test OK" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log and build.log"; exit 1; }
